//--- rp_io.f
src/rp_io_pkg.sv
src/adc_frontend.sv
src/dac_backend.sv
src/sys_bus_decoder.sv
src/housekeeping_regs.sv
src/capture_buffer.sv
src/scope_regs.sv
src/rp_io_top.sv
test/tb_rp_io_top.sv

//--- Bender.yml
package:
  name: rp_io

sources:
  - src/rp_io_pkg.sv
  - src/adc_frontend.sv
  - src/dac_backend.sv
  - src/sys_bus_decoder.sv
  - src/housekeeping_regs.sv
  - src/capture_buffer.sv
  - src/scope_regs.sv
  - src/rp_io_top.sv
  - target: test
    files:
      - test/tb_rp_io_top.sv

//--- test/tb_rp_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rp_io_top
  import rp_io_pkg::*;
();

  localparam int        CLK_NS  = 8;
  localparam int        HK_N    = 4;    // random housekeeping rounds
  localparam int        TXN_N   = 256;  // planned bus transactions, upper bound
  localparam bus_word_t HK_BASE = 32'h0000_0000;
  localparam bus_word_t SC_BASE = 32'h0010_0000;  // region 1

  logic        adc_clk;
  logic        rst_n_i;
  adc_raw_t    adc_a, adc_b;
  adc_raw_t    dac_a_pin, dac_b_pin;
  logic [7:0]  led;
  sys_req_t    sys_req;
  sys_rsp_t    sys_rsp;
  logic [31:0] seed;
  logic [31:0] noise_state;  // separate stream for pin noise
  logic        pin_noise;

  rp_io_top u_rp_io_top (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_dat_a_i (adc_a),
    .adc_dat_b_i (adc_b),
    .dac_dat_a_o (dac_a_pin),
    .dac_dat_b_o (dac_b_pin),
    .led_o       (led),
    .sys_req_i   (sys_req),
    .sys_rsp_o   (sys_rsp)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #(CLK_NS/2) adc_clk = ~adc_clk;
  end

  ////////////////////
  // model helpers
  ////////////////////
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // negative slope code, msb kept, lower 13 bits inverted
  function automatic adc_raw_t flip_low(input adc_raw_t v);
    return v ^ {1'b0, {(ADC_W-1){1'b1}}};
  endfunction

  function automatic bus_word_t sext14(input logic [ADC_W-1:0] v);
    return {{(BUS_W-ADC_W){v[ADC_W-1]}}, v};
  endfunction

  // b in upper half, a in lower half, each sign-extended to 16 bits
  function automatic bus_word_t pack_pair(input logic [ADC_W-1:0] a, input logic [ADC_W-1:0] b);
    return {{(16-ADC_W){b[ADC_W-1]}}, b, {(16-ADC_W){a[ADC_W-1]}}, a};
  endfunction

  task automatic check_eq(input string name, input bus_word_t exp, input bus_word_t act);
    if (exp !== act)
    begin
      $display("[FAIL] %0t ns %s expected 0x%08h got 0x%08h", $time, name, exp, act);
      $display("Result: FAILED");
      $fatal(1);
    end
  endtask

  ////////////////////
  // bus master
  ////////////////////
  task automatic bus_xfer(input logic write, input bus_word_t addr, input bus_word_t wdata,
                          output bus_word_t rdata, output logic err);
    int   waited;
    logic got;
    @(posedge adc_clk);
    sys_req.addr  <= addr;   // held until next transfer
    sys_req.wdata <= wdata;
    sys_req.wen   <= write;
    sys_req.ren   <= !write;
    got    = 1'b0;
    waited = 0;
    rdata  = '0;
    err    = 1'b0;
    while (!got)
    begin
      @(negedge adc_clk);  // sample mid cycle
      if (sys_rsp.ack)
      begin
        got   = 1'b1;
        rdata = sys_rsp.rdata;
        err   = sys_rsp.err;
      end
      @(posedge adc_clk);
      sys_req.wen <= 1'b0;  // strobe lasts one cycle
      sys_req.ren <= 1'b0;
      waited++;
      if (!got && waited > 16)
      begin
        $display("bus transfer to 0x%08h got no ack within 16 cycles", addr);
        $display("Result: FAILED");
        $fatal(1);
      end
    end
  endtask

  task automatic read_check(input string name, input bus_word_t addr,
                            input bus_word_t exp_data, input logic exp_err);
    bus_word_t rd;
    logic      e;
    bus_xfer(1'b0, addr, '0, rd, e);
    check_eq({name, " err"}, 32'(exp_err), 32'(e));
    check_eq(name, exp_data, rd);
  endtask

  task automatic write_reg(input string name, input bus_word_t addr, input bus_word_t data,
                           input logic exp_err);
    bus_word_t rd;
    logic      e;
    bus_xfer(1'b1, addr, data, rd, e);
    check_eq({name, " err"}, 32'(exp_err), 32'(e));
  endtask

  // poll ctrl until the done bit shows up
  task automatic wait_capture_done();
    bus_word_t rd;
    logic      e;
    int        polls;
    polls = 0;
    rd    = '0;
    while (!rd[1])
    begin
      bus_xfer(1'b0, SC_BASE + SC_CTRL_OFS, '0, rd, e);
      polls++;
      if (polls > 100)
      begin
        $display("capture did not finish after %0d status polls", polls);
        $display("Result: FAILED");
        $fatal(1);
      end
    end
  endtask

  task automatic check_capture(input logic [ADC_W-1:0] a, input logic [ADC_W-1:0] b);
    for (int i = 0; i < CAPTURE_DEPTH; i++)
      read_check($sformatf("capture word %0d", i), SC_BASE + SC_DATA_BASE + 4*i,
                 pack_pair(a, b), 1'b0);
  endtask

  // random pin activity, only matters with loopback off
  always @(posedge adc_clk)
  begin
    if (pin_noise)
    begin
      noise_state = lcg_next(noise_state);
      adc_a <= noise_state[13:0];
      adc_b <= noise_state[29:16];
    end
  end

  initial
  begin
    #((TXN_N * 64 + 2 * CAPTURE_DEPTH) * CLK_NS);
    $display("watchdog expired before the tests completed");
    $display("Result: FAILED");
    $fatal(1);
  end

  ////////////////////
  // test sequence
  ////////////////////
  initial
  begin
    adc_raw_t         pin_a, pin_b;
    logic [ADC_W-1:0] dac_a, dac_b;
    logic [7:0]       led_val;
    seed        = 32'd28946;
    noise_state = lcg_next(32'd28946);
    pin_noise   = 1'b0;
    rst_n_i     = 1'b0;
    adc_a       = '0;
    adc_b       = '0;
    sys_req     = '0;
    dac_a       = '0;
    dac_b       = '0;
    repeat (2) @(posedge adc_clk);
    rst_n_i <= 1'b1;

    // reset values
    @(negedge adc_clk);
    check_eq("dac_dat_a_o", 32'h1FFF, 32'(dac_a_pin));
    check_eq("dac_dat_b_o", 32'h1FFF, 32'(dac_b_pin));
    check_eq("led_o", 32'h0, 32'(led));
    read_check("id", HK_BASE + HK_ID_OFS, RP_ID, 1'b0);

    // housekeeping write and readback
    for (int k = 0; k < HK_N; k++)
    begin
      seed    = lcg_next(seed);
      led_val = seed[7:0];
      write_reg("led wr", HK_BASE + HK_LED_OFS, seed, 1'b0);
      seed  = lcg_next(seed);
      dac_a = seed[ADC_W-1:0];
      write_reg("dac a wr", HK_BASE + HK_DAC_A_OFS, seed, 1'b0);
      seed  = lcg_next(seed);
      dac_b = seed[ADC_W-1:0];
      write_reg("dac b wr", HK_BASE + HK_DAC_B_OFS, seed, 1'b0);
      read_check("led rd", HK_BASE + HK_LED_OFS, 32'(led_val), 1'b0);
      read_check("dac a rd", HK_BASE + HK_DAC_A_OFS, sext14(dac_a), 1'b0);
      read_check("dac b rd", HK_BASE + HK_DAC_B_OFS, sext14(dac_b), 1'b0);
      repeat (3) @(negedge adc_clk);
      check_eq("led_o", 32'(led_val), 32'(led));
      check_eq("dac_dat_a_o", 32'(flip_low(dac_a)), 32'(dac_a_pin));
      check_eq("dac_dat_b_o", 32'(flip_low(dac_b)), 32'(dac_b_pin));
    end
    write_reg("id wr", HK_BASE + HK_ID_OFS, lcg_next(seed), 1'b0);  // ignored
    read_check("id after wr", HK_BASE + HK_ID_OFS, RP_ID, 1'b0);
    read_check("hk unmapped", HK_BASE + 32'h14, 32'h0, 1'b1);

    // capture of constant adc pins
    seed  = lcg_next(seed);
    pin_a = seed[13:0];
    pin_b = seed[29:16];
    @(posedge adc_clk);
    adc_a <= pin_a;
    adc_b <= pin_b;
    write_reg("loop off", HK_BASE + HK_LOOP_OFS, 32'h0, 1'b0);
    read_check("loop rd", HK_BASE + HK_LOOP_OFS, 32'h0, 1'b0);
    write_reg("arm", SC_BASE + SC_CTRL_OFS, 32'h1, 1'b0);
    wait_capture_done();
    check_capture(flip_low(pin_a), flip_low(pin_b));
    read_check("wr ptr", SC_BASE + SC_PTR_OFS, CAPTURE_DEPTH - 1, 1'b0);
    read_check("status done", SC_BASE + SC_CTRL_OFS, 32'h2, 1'b0);  // armed 0, done 1

    // loopback capture, pins toggling underneath
    write_reg("loop on", HK_BASE + HK_LOOP_OFS, 32'h1, 1'b0);
    read_check("loop rd", HK_BASE + HK_LOOP_OFS, 32'h1, 1'b0);
    seed  = lcg_next(seed);
    dac_a = seed[ADC_W-1:0];
    write_reg("dac a wr", HK_BASE + HK_DAC_A_OFS, seed, 1'b0);
    seed  = lcg_next(seed);
    dac_b = seed[ADC_W-1:0];
    write_reg("dac b wr", HK_BASE + HK_DAC_B_OFS, seed, 1'b0);
    pin_noise <= 1'b1;
    write_reg("re-arm", SC_BASE + SC_CTRL_OFS, 32'h1, 1'b0);
    read_check("status re-armed", SC_BASE + SC_CTRL_OFS, 32'h1, 1'b0);
    wait_capture_done();
    check_capture(dac_a, dac_b);
    pin_noise <= 1'b0;

    // empty regions and bad scope accesses
    for (int k = 0; k < 8; k++)
    begin
      seed = lcg_next(seed);
      read_check("empty region",
                 {9'd0, region_t'(32'd2 + seed % 32'd6), seed[REGION_LSB-1:0]}, 32'h0, 1'b0);
    end
    read_check("scope past window", SC_BASE + SC_DATA_BASE + 4*CAPTURE_DEPTH, 32'h0, 1'b1);
    write_reg("ptr wr", SC_BASE + SC_PTR_OFS, 32'h0, 1'b1);  // read only

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/rp_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module rp_io_top
  import rp_io_pkg::*;
(
  input  wire logic     adc_clk,
  input  wire logic     rst_n_i,
  input  wire adc_raw_t adc_dat_a_i,
  input  wire adc_raw_t adc_dat_b_i,
  output adc_raw_t      dac_dat_a_o,
  output adc_raw_t      dac_dat_b_o,
  output logic [7:0]    led_o,
  input  wire sys_req_t sys_req_i,  // system bus in
  output sys_rsp_t      sys_rsp_o
);

  sample_pair_t samples;       // adc stream
  sample_pair_t dac_set;       // hk set values
  logic         digital_loop;
  sys_req_t     hk_req, sc_req;
  sys_rsp_t     hk_rsp, sc_rsp;
  logic         arm, armed, done;
  cap_addr_t    rd_addr, wr_ptr;
  sample_pair_t rd_data;

  ////////////////////
  // analog io
  ////////////////////
  adc_frontend u_adc_frontend (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .loop_i      (digital_loop),
    .dac_set_i   (dac_set),
    .samples_o   (samples)
  );

  dac_backend u_dac_backend (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .dac_set_i   (dac_set),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

  ////////////////////
  // bus and slaves
  ////////////////////
  sys_bus_decoder u_sys_bus_decoder (
    .sys_req_i (sys_req_i),
    .sys_rsp_o (sys_rsp_o),
    .hk_req_o  (hk_req),
    .sc_req_o  (sc_req),
    .hk_rsp_i  (hk_rsp),
    .sc_rsp_i  (sc_rsp)
  );

  housekeeping_regs u_housekeeping_regs (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .req_i     (hk_req),
    .rsp_o     (hk_rsp),
    .loop_o    (digital_loop),
    .led_o     (led_o),
    .dac_set_o (dac_set)
  );

  capture_buffer u_capture_buffer (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .samples_i (samples),
    .arm_i     (arm),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data),
    .wr_ptr_o  (wr_ptr),
    .armed_o   (armed),
    .done_o    (done)
  );

  scope_regs u_scope_regs (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .req_i     (sc_req),
    .rsp_o     (sc_rsp),
    .arm_o     (arm),
    .rd_addr_o (rd_addr),
    .rd_data_i (rd_data),
    .wr_ptr_i  (wr_ptr),
    .armed_i   (armed),
    .done_i    (done)
  );

endmodule

`default_nettype wire

//--- src/scope_regs.sv
`timescale 1ns/1ps
`default_nettype none

module scope_regs
  import rp_io_pkg::*;
(
  input  wire logic         adc_clk,
  input  wire logic         rst_n_i,
  input  wire sys_req_t     req_i,
  output sys_rsp_t          rsp_o,
  output logic              arm_o,      // one cycle pulse
  output cap_addr_t         rd_addr_o,  // to capture ram
  input  wire sample_pair_t rd_data_i,
  input  wire cap_addr_t    wr_ptr_i,
  input  wire logic         armed_i,
  input  wire logic         done_i
);

  logic [REGION_LSB-1:0] ofs;
  logic                  in_win;    // offset hits data window
  logic                  win_pend;  // ram read in flight
  bus_word_t             reg_data;
  logic                  reg_err;

  assign ofs       = req_i.addr[REGION_LSB-1:0];
  assign in_win    = ofs[REGION_LSB-1:CAP_AW+2] == SC_DATA_BASE[REGION_LSB-1:CAP_AW+2];
  assign rd_addr_o = ofs[2 +: CAP_AW];  // word index, addr held till ack

  // register reads
  always_comb
  begin
    reg_data = '0;
    reg_err  = 1'b0;
    case (ofs)
      SC_CTRL_OFS: reg_data = BUS_W'({done_i, armed_i});
      SC_PTR_OFS:  reg_data = BUS_W'(wr_ptr_i);
      default:     reg_err  = 1'b1;
    endcase
  end

  ////////////////////
  // response, ack +1 for regs, +2 for window
  ////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      arm_o    <= 1'b0;
      win_pend <= 1'b0;
      rsp_o    <= '0;
    end
    else
    begin
      arm_o    <= req_i.wen && (ofs == SC_CTRL_OFS) && req_i.wdata[0];
      win_pend <= req_i.ren && in_win;
      rsp_o    <= '0;
      if (win_pend)
      begin
        // b high half, a low half, both sign-extended
        rsp_o.rdata <= {(BUS_W/2)'(rd_data_i.b), (BUS_W/2)'(rd_data_i.a)};
        rsp_o.ack   <= 1'b1;
      end
      else if (req_i.wen)
      begin
        rsp_o.err <= (ofs != SC_CTRL_OFS);  // only ctrl is writable
        rsp_o.ack <= 1'b1;
      end
      else if (req_i.ren && !in_win)
      begin
        rsp_o.rdata <= reg_data;
        rsp_o.err   <= reg_err;
        rsp_o.ack   <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/capture_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module capture_buffer
  import rp_io_pkg::*;
(
  input  wire logic         adc_clk,
  input  wire logic         rst_n_i,
  input  wire sample_pair_t samples_i,  // one pair per cycle
  input  wire logic         arm_i,      // start or restart run
  input  wire cap_addr_t    rd_addr_i,
  output sample_pair_t      rd_data_o,  // valid one cycle after addr
  output cap_addr_t         wr_ptr_o,
  output logic              armed_o,
  output logic              done_o
);

  sample_pair_t mem [CAPTURE_DEPTH];  // capture ram
  logic         last;                 // writing final index

  assign last = (wr_ptr_o == cap_addr_t'(CAPTURE_DEPTH - 1));

  ////////////////////
  // run control
  ////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_o <= '0;
      armed_o  <= 1'b0;
      done_o   <= 1'b0;
    end
    else if (arm_i)
    begin
      wr_ptr_o <= '0;    // restart even mid run
      armed_o  <= 1'b1;
      done_o   <= 1'b0;
    end
    else if (armed_o)
    begin
      if (last)
      begin
        armed_o <= 1'b0;  // ptr stays on last index
        done_o  <= 1'b1;
      end
      else
        wr_ptr_o <= wr_ptr_o + 1'b1;
    end
  end

  // ram write while armed, sync read port
  always_ff @(posedge adc_clk)
  begin
    if (armed_o)
      mem[wr_ptr_o] <= samples_i;
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

`default_nettype wire

//--- src/housekeeping_regs.sv
`timescale 1ns/1ps
`default_nettype none

module housekeeping_regs
  import rp_io_pkg::*;
(
  input  wire logic     adc_clk,
  input  wire logic     rst_n_i,
  input  wire sys_req_t req_i,
  output sys_rsp_t      rsp_o,
  output logic          loop_o,     // digital loopback
  output logic [7:0]    led_o,
  output sample_pair_t  dac_set_o   // dac set values a/b
);

  logic [REGION_LSB-1:0] ofs;
  bus_word_t             rd_data;
  logic                  map_err;  // offset not mapped

  assign ofs = req_i.addr[REGION_LSB-1:0];

  ////////////////////
  // register writes
  ////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      loop_o    <= 1'b0;
      led_o     <= '0;
      dac_set_o <= '0;
    end
    else if (req_i.wen)
    begin
      case (ofs)
        HK_LOOP_OFS:  loop_o      <= req_i.wdata[0];
        HK_LED_OFS:   led_o       <= req_i.wdata[7:0];
        HK_DAC_A_OFS: dac_set_o.a <= sample_t'(req_i.wdata[ADC_W-1:0]);
        HK_DAC_B_OFS: dac_set_o.b <= sample_t'(req_i.wdata[ADC_W-1:0]);
        default:      ;  // id is read only
      endcase
    end
  end

  // read mux, signed cast sign-extends dac values
  always_comb
  begin
    rd_data = '0;
    map_err = 1'b0;
    case (ofs)
      HK_ID_OFS:    rd_data = RP_ID;
      HK_LOOP_OFS:  rd_data = BUS_W'(loop_o);
      HK_LED_OFS:   rd_data = BUS_W'(led_o);
      HK_DAC_A_OFS: rd_data = BUS_W'(dac_set_o.a);
      HK_DAC_B_OFS: rd_data = BUS_W'(dac_set_o.b);
      default:      map_err = 1'b1;
    endcase
  end

  // single cycle response
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      rsp_o <= '0;
    else
    begin
      rsp_o.ack   <= req_i.wen | req_i.ren;
      rsp_o.err   <= (req_i.wen | req_i.ren) & map_err;
      rsp_o.rdata <= req_i.ren ? rd_data : '0;
    end
  end

endmodule

`default_nettype wire

//--- src/sys_bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module sys_bus_decoder
  import rp_io_pkg::*;
(
  input  wire sys_req_t sys_req_i,  // from bus master
  output sys_rsp_t      sys_rsp_o,
  output sys_req_t      hk_req_o,   // region 0
  output sys_req_t      sc_req_o,   // region 1
  input  wire sys_rsp_t hk_rsp_i,
  input  wire sys_rsp_t sc_rsp_i
);

  region_t             region;
  logic [REGION_N-1:0] cs;              // one-hot region select
  sys_rsp_t            rsp [REGION_N];  // per region response

  ////////////////////
  // request side
  ////////////////////
  assign region = sys_req_i.addr[REGION_LSB +: $bits(region_t)];
  assign cs     = REGION_N'(1) << region;

  // addr/wdata fan out as is, strobes gated by select
  always_comb
  begin
    hk_req_o     = sys_req_i;
    hk_req_o.wen = sys_req_i.wen & cs[0];
    hk_req_o.ren = sys_req_i.ren & cs[0];
    sc_req_o     = sys_req_i;
    sc_req_o.wen = sys_req_i.wen & cs[1];
    sc_req_o.ren = sys_req_i.ren & cs[1];
  end

  ////////////////////
  // response side
  ////////////////////
  always_comb
  begin
    rsp[0] = hk_rsp_i;
    rsp[1] = sc_rsp_i;
    // empty regions answer at once, zero data, no error
    for (int i = 2; i < REGION_N; i++)
    begin
      rsp[i].rdata = '0;
      rsp[i].err   = 1'b0;
      rsp[i].ack   = (sys_req_i.wen | sys_req_i.ren) & cs[i];
    end
  end

  // addr is held until ack so region still points at the right slave
  assign sys_rsp_o = rsp[region];

endmodule

`default_nettype wire

//--- src/dac_backend.sv
`timescale 1ns/1ps
`default_nettype none

module dac_backend
  import rp_io_pkg::*;
(
  input  wire logic         adc_clk,
  input  wire logic         rst_n_i,
  input  wire sample_pair_t dac_set_i,    // signed set values
  output adc_raw_t          dac_dat_a_o,  // negative slope offset code
  output adc_raw_t          dac_dat_b_o
);

  // output registers, zero code after reset
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      dac_dat_a_o <= neg_slope('0);  // 0x1FFF
      dac_dat_b_o <= neg_slope('0);
    end
    else
    begin
      dac_dat_a_o <= neg_slope(dac_set_i.a);
      dac_dat_b_o <= neg_slope(dac_set_i.b);
    end
  end

endmodule

`default_nettype wire

//--- src/adc_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module adc_frontend
  import rp_io_pkg::*;
(
  input  wire logic         adc_clk,
  input  wire logic         rst_n_i,
  input  wire adc_raw_t     adc_dat_a_i,  // raw pins ch a
  input  wire adc_raw_t     adc_dat_b_i,  // raw pins ch b
  input  wire logic         loop_i,       // digital loopback enable
  input  wire sample_pair_t dac_set_i,    // loopback source
  output sample_pair_t      samples_o
);

  adc_raw_t pin_a_q;  // io register stage
  adc_raw_t pin_b_q;

  // pins sampled every cycle, no enable
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      pin_a_q <= '0;
      pin_b_q <= '0;
    end
    else
    begin
      pin_a_q <= adc_dat_a_i;
      pin_b_q <= adc_dat_b_i;
    end
  end

  // negative slope unsigned -> two's complement, or loopback
  always_comb
  begin
    if (loop_i)
      samples_o = dac_set_i;  // dac values replace adc
    else
    begin
      samples_o.a = sample_t'(neg_slope(pin_a_q));
      samples_o.b = sample_t'(neg_slope(pin_b_q));
    end
  end

endmodule

`default_nettype wire

//--- src/rp_io_pkg.sv
`default_nettype none

package rp_io_pkg;

  ////////////////////
  // widths and sizes
  ////////////////////
  localparam int ADC_W         = 14;  // converter resolution
  localparam int REGION_N      = 8;   // bus regions
  localparam int REGION_LSB    = 20;  // region field starts here
  localparam int BUS_W         = 32;
  localparam int CAPTURE_DEPTH = 64;  // sample pairs per run
  localparam int CAP_AW        = 6;

  typedef logic        [ADC_W-1:0]            adc_raw_t;  // pin level code
  typedef logic signed [ADC_W-1:0]            sample_t;   // two's complement
  typedef logic        [$clog2(REGION_N)-1:0] region_t;
  typedef logic        [CAP_AW-1:0]           cap_addr_t;
  typedef logic        [BUS_W-1:0]            bus_word_t;

  typedef struct packed {
    sample_t a;  // channel a in upper half
    sample_t b;
  } sample_pair_t;

  typedef struct packed {
    bus_word_t addr;
    bus_word_t wdata;
    logic      wen;   // one cycle pulse
    logic      ren;   // one cycle pulse
  } sys_req_t;

  typedef struct packed {
    bus_word_t rdata;
    logic      err;
    logic      ack;
  } sys_rsp_t;

  localparam bus_word_t RP_ID = 32'h5250_0100;

  // housekeeping offsets within region 0
  localparam logic [REGION_LSB-1:0] HK_ID_OFS    = 'h00;
  localparam logic [REGION_LSB-1:0] HK_LOOP_OFS  = 'h04;
  localparam logic [REGION_LSB-1:0] HK_LED_OFS   = 'h08;
  localparam logic [REGION_LSB-1:0] HK_DAC_A_OFS = 'h0C;
  localparam logic [REGION_LSB-1:0] HK_DAC_B_OFS = 'h10;

  // scope offsets within region 1
  localparam logic [REGION_LSB-1:0] SC_CTRL_OFS  = 'h00;
  localparam logic [REGION_LSB-1:0] SC_PTR_OFS   = 'h04;
  localparam logic [REGION_LSB-1:0] SC_DATA_BASE = 'h1000;  // one word per index

  // keep msb, flip the rest. same mapping both directions
  function automatic adc_raw_t neg_slope(input logic [ADC_W-1:0] v);
    return {v[ADC_W-1], ~v[ADC_W-2:0]};
  endfunction

endpackage

`default_nettype wire
